/* design/cl_ro_pkg.sv */
package cl_ro_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned axi_addr_w = 32;
  localparam int unsigned axi_data_w = 32;
  localparam int unsigned axi_strb_w = 4;

  // Only response ever returned
  localparam logic [1:0] axi_resp_okay = 2'b00;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------
  // Virtual LED and DIP buses
  localparam int unsigned vled_w = 16;
  // Event counter and its prescaler
  localparam int unsigned cnt_w  = 16;
  localparam int unsigned tick_w = 8;

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam logic [axi_addr_w-1:0] hello_world_addr   = 32'h0000_0500;
  localparam logic [axi_addr_w-1:0] vled_addr          = 32'h0000_0504;
  localparam logic [axi_addr_w-1:0] cnt_ctrl_addr      = 32'h0000_0508;
  // Load value and watermark live in bits 15:0
  localparam logic [axi_addr_w-1:0] cnt_load_addr      = 32'h0000_050C;
  localparam logic [axi_addr_w-1:0] cnt_watermark_addr = 32'h0000_0510;
  // Read only: {6'b0, ge_watermark, tick, prescaler, count}
  localparam logic [axi_addr_w-1:0] cnt_status_addr    = 32'h0000_0514;

  // Returned for any address not in the map
  localparam logic [axi_data_w-1:0] unmapped_read_value = 32'hDEAD_DEAD;

  // Counter control word, seen as a bus word or as fields
  typedef union packed {
    logic [axi_data_w-1:0] raw;
    struct packed {
      logic [15:0]       rsvd_hi;
      logic [tick_w-1:0] tick_value;
      logic [3:0]        rsvd_lo;
      logic              oneshot;
      // Self-clearing command bits
      logic              clear;
      logic              load;
      logic              enable;
    } fields;
  } cnt_ctrl_t;

endpackage

/* design/ocl_slave.sv */
module ocl_slave (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  // Write address channel
  input  logic                            awvalid,
  input  logic [cl_ro_pkg::axi_addr_w-1:0] awaddr,
  output logic                            awready,
  // Write data channel
  input  logic                            wvalid,
  input  logic [cl_ro_pkg::axi_data_w-1:0] wdata,
  input  logic [cl_ro_pkg::axi_strb_w-1:0] wstrb,
  output logic                            wready,
  // Write response channel
  output logic                            bvalid,
  output logic [1:0]                      bresp,
  input  logic                            bready,
  // Read address channel
  input  logic                            arvalid,
  input  logic [cl_ro_pkg::axi_addr_w-1:0] araddr,
  output logic                            arready,
  // Read data channel
  output logic                            rvalid,
  output logic [cl_ro_pkg::axi_data_w-1:0] rdata,
  output logic [1:0]                      rresp,
  input  logic                            rready,
  // Register file side
  output logic                            wr_en,
  output logic [cl_ro_pkg::axi_addr_w-1:0] wr_addr,
  output logic [cl_ro_pkg::axi_data_w-1:0] wr_data,
  output logic                            rd_en,
  output logic [cl_ro_pkg::axi_addr_w-1:0] rd_addr,
  input  logic [cl_ro_pkg::axi_data_w-1:0] rd_data
);
  import cl_ro_pkg::*;

  logic wr_active;
  logic aw_xfer;
  logic b_xfer;
  logic ar_xfer;
  logic r_xfer;

  // ----------------------------------------
  // Write path
  // ----------------------------------------
  // One write in flight, AW opens it and B closes it
  assign awready = !wr_active;
  assign aw_xfer = awvalid && awready;
  // W open only until the response is raised
  assign wready  = wr_active && !bvalid && wvalid;
  assign b_xfer  = bvalid && bready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      if (b_xfer) begin
        wr_active <= 1'b0;
      end else if (aw_xfer) begin
        wr_active <= 1'b1;
      end
      // Response on the cycle after the data beat
      if (b_xfer) begin
        bvalid <= 1'b0;
      end else if (wready) begin
        bvalid <= 1'b1;
      end
    end
  end

  // Address held for the whole write
  always_ff @(posedge clk_main_a0) begin
    if (aw_xfer) begin
      wr_addr <= awaddr;
    end
  end

  // Register write strobe on the W beat
  // Byte strobes not supported, full word always stored
  assign wr_en   = wready;
  assign wr_data = wdata;
  assign bresp   = axi_resp_okay;

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  // rd_en doubles as read-pending
  assign arready = !rd_en && !rvalid;
  assign ar_xfer = arvalid && arready;
  assign r_xfer  = rvalid && rready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_en  <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      rd_en <= ar_xfer;
      // Data lands in the register file on the same edge
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (r_xfer) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_xfer) begin
      rd_addr <= araddr;
    end
  end

  // Read data is held by the register file until the next rd_en
  assign rdata = rd_data;
  assign rresp = axi_resp_okay;

endmodule

/* design/ocl_regs.sv */
module ocl_regs (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  // Write port, one cycle per beat
  input  logic                            wr_en,
  input  logic [cl_ro_pkg::axi_addr_w-1:0] wr_addr,
  input  logic [cl_ro_pkg::axi_data_w-1:0] wr_data,
  // Read port, data the cycle after rd_en
  input  logic                            rd_en,
  input  logic [cl_ro_pkg::axi_addr_w-1:0] rd_addr,
  output logic [cl_ro_pkg::axi_data_w-1:0] rd_data,
  // Status sources
  input  logic [cl_ro_pkg::vled_w-1:0]     vled,
  input  logic [cl_ro_pkg::axi_data_w-1:0] cnt_status,
  // Hello-world word to the LED block
  output logic [cl_ro_pkg::axi_data_w-1:0] hello_q,
  // Counter controls
  output logic                            cnt_enable,
  output logic                            cnt_oneshot,
  output logic                            cnt_load,
  output logic                            cnt_clear,
  output logic [cl_ro_pkg::tick_w-1:0]     tick_value,
  output logic [cl_ro_pkg::cnt_w-1:0]      load_value,
  output logic [cl_ro_pkg::cnt_w-1:0]      watermark
);
  import cl_ro_pkg::*;

  logic                  hello_we;
  logic                  ctrl_we;
  logic                  load_we;
  logic                  wm_we;
  cnt_ctrl_t             ctrl_wr;
  cnt_ctrl_t             ctrl_next;
  cnt_ctrl_t             ctrl_q;
  logic [axi_data_w-1:0] hello_swapped;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  assign hello_we = wr_en && (wr_addr == hello_world_addr);
  assign ctrl_we  = wr_en && (wr_addr == cnt_ctrl_addr);
  assign load_we  = wr_en && (wr_addr == cnt_load_addr);
  assign wm_we    = wr_en && (wr_addr == cnt_watermark_addr);

  // Bus word in, fields out
  // Stored copy keeps only level bits, commands and reserved read 0
  always_comb begin
    ctrl_wr.raw                 = wr_data;
    ctrl_next.raw               = '0;
    ctrl_next.fields.enable     = ctrl_wr.fields.enable;
    ctrl_next.fields.oneshot    = ctrl_wr.fields.oneshot;
    ctrl_next.fields.tick_value = ctrl_wr.fields.tick_value;
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q    <= '0;
      ctrl_q.raw <= '0;
      load_value <= '0;
      watermark  <= '0;
      cnt_load   <= 1'b0;
      cnt_clear  <= 1'b0;
    end else begin
      if (hello_we) begin
        hello_q <= wr_data;
      end
      if (ctrl_we) begin
        ctrl_q <= ctrl_next;
      end
      if (load_we) begin
        load_value <= wr_data[cnt_w-1:0];
      end
      if (wm_we) begin
        watermark <= wr_data[cnt_w-1:0];
      end
      // One-cycle command pulses
      cnt_load  <= ctrl_we && ctrl_wr.fields.load;
      cnt_clear <= ctrl_we && ctrl_wr.fields.clear;
    end
  end

  assign cnt_enable  = ctrl_q.fields.enable;
  assign cnt_oneshot = ctrl_q.fields.oneshot;
  assign tick_value  = ctrl_q.fields.tick_value;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  // Hello-world reads back byte-reversed
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // Only updated on a read, so the word holds through a stalled R
  always_ff @(posedge clk_main_a0) begin
    if (rd_en) begin
      case (rd_addr)
        hello_world_addr:   rd_data <= hello_swapped;
        vled_addr:          rd_data <= {{(axi_data_w-vled_w){1'b0}}, vled};
        cnt_ctrl_addr:      rd_data <= ctrl_q.raw;
        cnt_load_addr:      rd_data <= {{(axi_data_w-cnt_w){1'b0}}, load_value};
        cnt_watermark_addr: rd_data <= {{(axi_data_w-cnt_w){1'b0}}, watermark};
        cnt_status_addr:    rd_data <= cnt_status;
        default:            rd_data <= unmapped_read_value;
      endcase
    end
  end

endmodule

/* design/vled_status.sv */
module vled_status (
  input  logic                        clk_main_a0,
  input  logic                        rst_main_n_sync,
  // Low half of hello-world
  input  logic [cl_ro_pkg::vled_w-1:0] hello_lo,
  // Asynchronous DIP switches from the shell
  input  logic [cl_ro_pkg::vled_w-1:0] vdip,
  // LED shadow for read-back
  output logic [cl_ro_pkg::vled_w-1:0] vled,
  // Masked LEDs to the shell
  output logic [cl_ro_pkg::vled_w-1:0] status_vled
);
  import cl_ro_pkg::*;

  logic [vled_w-1:0] vdip_q;
  logic [vled_w-1:0] vdip_q2;

  // ----------------------------------------
  // DIP sync and LED output
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q      <= '0;
      vdip_q2     <= '0;
      vled        <= '0;
      status_vled <= '0;
    end else begin
      // Two flops before the DIP bits are used
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
      // Shadow trails hello-world by one cycle
      vled <= hello_lo;
      // A lit LED needs its switch on
      status_vled <= vled & vdip_q2;
    end
  end

endmodule

/* design/tick_counter.sv */
module tick_counter (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  input  logic                            cnt_enable,
  input  logic                            cnt_oneshot,
  // Single-cycle commands, clear wins
  input  logic                            cnt_load,
  input  logic                            cnt_clear,
  input  logic [cl_ro_pkg::tick_w-1:0]     tick_value,
  input  logic [cl_ro_pkg::cnt_w-1:0]      load_value,
  input  logic [cl_ro_pkg::cnt_w-1:0]      watermark,
  output logic [cl_ro_pkg::axi_data_w-1:0] cnt_status
);
  import cl_ro_pkg::*;

  logic [tick_w-1:0] tick_cnt;
  logic [cnt_w-1:0]  cnt;
  logic              tick;
  logic              at_max;
  logic              ge_watermark;

  // Prescaler terminal, tick_value 0 ticks every cycle
  assign tick   = tick_cnt >= tick_value;
  assign at_max = cnt == {cnt_w{1'b1}};

  // ----------------------------------------
  // Prescaler and count
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt <= '0;
      cnt      <= '0;
    end else begin
      if (cnt_clear) begin
        tick_cnt <= '0;
      end else if (cnt_enable) begin
        tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      end
      // Clear, then load, then hold when disabled
      if (cnt_clear) begin
        cnt <= '0;
      end else if (cnt_load) begin
        cnt <= load_value;
      end else if (cnt_enable && tick) begin
        // One-shot parks at all ones, otherwise wrap
        if (!(cnt_oneshot && at_max)) begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Compare on the registered count so the status word agrees with itself
  assign ge_watermark = cnt >= watermark;

  assign cnt_status = {{(axi_data_w-cnt_w-tick_w-2){1'b0}}, ge_watermark, tick,
                       tick_cnt, cnt};

endmodule

/* design/cl_ro_top.sv */
module cl_ro_top (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  // AXI-Lite from the host
  input  logic                            sh_ocl_awvalid,
  input  logic [cl_ro_pkg::axi_addr_w-1:0] sh_ocl_awaddr,
  output logic                            ocl_sh_awready,
  input  logic                            sh_ocl_wvalid,
  input  logic [cl_ro_pkg::axi_data_w-1:0] sh_ocl_wdata,
  input  logic [cl_ro_pkg::axi_strb_w-1:0] sh_ocl_wstrb,
  output logic                            ocl_sh_wready,
  output logic                            ocl_sh_bvalid,
  output logic [1:0]                      ocl_sh_bresp,
  input  logic                            sh_ocl_bready,
  input  logic                            sh_ocl_arvalid,
  input  logic [cl_ro_pkg::axi_addr_w-1:0] sh_ocl_araddr,
  output logic                            ocl_sh_arready,
  output logic                            ocl_sh_rvalid,
  output logic [cl_ro_pkg::axi_data_w-1:0] ocl_sh_rdata,
  output logic [1:0]                      ocl_sh_rresp,
  input  logic                            sh_ocl_rready,
  // Virtual switches and LEDs
  input  logic [cl_ro_pkg::vled_w-1:0]     sh_cl_status_vdip,
  output logic [cl_ro_pkg::vled_w-1:0]     cl_sh_status_vled
);
  import cl_ro_pkg::*;

  // Slave to register file
  logic                  wr_en;
  logic [axi_addr_w-1:0] wr_addr;
  logic [axi_data_w-1:0] wr_data;
  logic                  rd_en;
  logic [axi_addr_w-1:0] rd_addr;
  logic [axi_data_w-1:0] rd_data;
  // Register file to LED block and counter
  logic [axi_data_w-1:0] hello_q;
  logic [vled_w-1:0]     vled;
  logic                  cnt_enable;
  logic                  cnt_oneshot;
  logic                  cnt_load;
  logic                  cnt_clear;
  logic [tick_w-1:0]     tick_value;
  logic [cnt_w-1:0]      load_value;
  logic [cnt_w-1:0]      watermark;
  logic [axi_data_w-1:0] cnt_status;

  // ----------------------------------------
  // Bus slave and registers
  // ----------------------------------------
  ocl_slave u_ocl_slave (
    .clk_main_a0, .rst_main_n_sync,
    .awvalid (sh_ocl_awvalid), .awaddr (sh_ocl_awaddr), .awready (ocl_sh_awready),
    .wvalid  (sh_ocl_wvalid),  .wdata  (sh_ocl_wdata),  .wstrb   (sh_ocl_wstrb),
    .wready  (ocl_sh_wready),
    .bvalid  (ocl_sh_bvalid),  .bresp  (ocl_sh_bresp),  .bready  (sh_ocl_bready),
    .arvalid (sh_ocl_arvalid), .araddr (sh_ocl_araddr), .arready (ocl_sh_arready),
    .rvalid  (ocl_sh_rvalid),  .rdata  (ocl_sh_rdata),  .rresp   (ocl_sh_rresp),
    .rready  (sh_ocl_rready),
    .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
  );

  ocl_regs u_ocl_regs (
    .clk_main_a0, .rst_main_n_sync,
    .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data,
    .vled, .cnt_status, .hello_q,
    .cnt_enable, .cnt_oneshot, .cnt_load, .cnt_clear,
    .tick_value, .load_value, .watermark
  );

  // ----------------------------------------
  // LEDs and event counter
  // ----------------------------------------
  vled_status u_vled_status (
    .clk_main_a0, .rst_main_n_sync,
    .hello_lo    (hello_q[vled_w-1:0]),
    .vdip        (sh_cl_status_vdip),
    .vled,
    .status_vled (cl_sh_status_vled)
  );

  tick_counter u_tick_counter (
    .clk_main_a0, .rst_main_n_sync,
    .cnt_enable, .cnt_oneshot, .cnt_load, .cnt_clear,
    .tick_value, .load_value, .watermark, .cnt_status
  );

endmodule

/* tests/clk_gen.sv */
module clk_gen (
  output logic clk_main_a0,
  output logic rst_main_n_sync
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 5;

  // 40 ns period
  initial begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  // Released just after the fifth rising edge
  initial begin
    rst_main_n_sync = 1'b0;
    repeat (reset_cycles) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
  end

endmodule

/* tests/cl_ro_properties.sv */
module cl_ro_properties (
  input logic                             clk_main_a0,
  input logic                             rst_main_n_sync,
  input logic                             arready,
  input logic                             bvalid,
  input logic                             bready,
  input logic [1:0]                       bresp,
  input logic                             rvalid,
  input logic                             rready,
  input logic [1:0]                       rresp,
  input logic [cl_ro_pkg::axi_data_w-1:0] rdata
);
  timeunit 1ns;
  timeprecision 1ps;
  import cl_ro_pkg::*;

  // Running tally of failed properties
  int unsigned fail_count = 0;

  // ----------------------------------------
  // Response channels
  // ----------------------------------------
  // B held until taken
  bvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
  else begin
    fail_count++;
    $error("bvalid dropped before bready");
  end

  // R held with the same word until taken
  rvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
  else begin
    fail_count++;
    $error("rvalid or rdata changed before rready");
  end

  // No new read while a response waits
  ar_blocked: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid |-> !arready)
  else begin
    fail_count++;
    $error("arready high while rvalid is pending");
  end

  bresp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid |-> bresp == axi_resp_okay)
  else begin
    fail_count++;
    $error("bresp is not okay");
  end

  rresp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid |-> rresp == axi_resp_okay)
  else begin
    fail_count++;
    $error("rresp is not okay");
  end

endmodule

bind ocl_slave cl_ro_properties u_props (
  .clk_main_a0, .rst_main_n_sync, .arready, .bvalid, .bready, .bresp,
  .rvalid, .rready, .rresp, .rdata
);

/* tests/tb_cl_ro.sv */
module tb_cl_ro;
  timeunit 1ns;
  timeprecision 1ps;
  import cl_ro_pkg::*;

  localparam int bus_timeout   = 50;
  localparam int vled_timeout  = 8;
  localparam int reset_timeout = 20;

  logic                  clk_main_a0;
  logic                  rst_main_n_sync;
  logic                  sh_ocl_awvalid;
  logic [axi_addr_w-1:0] sh_ocl_awaddr;
  logic                  ocl_sh_awready;
  logic                  sh_ocl_wvalid;
  logic [axi_data_w-1:0] sh_ocl_wdata;
  logic [axi_strb_w-1:0] sh_ocl_wstrb;
  logic                  ocl_sh_wready;
  logic                  ocl_sh_bvalid;
  logic [1:0]            ocl_sh_bresp;
  logic                  sh_ocl_bready;
  logic                  sh_ocl_arvalid;
  logic [axi_addr_w-1:0] sh_ocl_araddr;
  logic                  ocl_sh_arready;
  logic                  ocl_sh_rvalid;
  logic [axi_data_w-1:0] ocl_sh_rdata;
  logic [1:0]            ocl_sh_rresp;
  logic                  sh_ocl_rready;
  logic [vled_w-1:0]     sh_cl_status_vdip;
  logic [vled_w-1:0]     cl_sh_status_vled;
  integer                seed;
  int                    mismatch_count;
  int                    timeout_count;

  clk_gen u_clk_gen (.clk_main_a0, .rst_main_n_sync);

  cl_ro_top UUT (.*);

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Hello-world bytes come back in reverse order
  function automatic logic [axi_data_w-1:0] byte_swap(input logic [axi_data_w-1:0] w);
    logic [axi_data_w-1:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
  endfunction

  function automatic logic [axi_data_w-1:0] ctrl_word(input logic enable, input logic load,
      input logic clear, input logic oneshot, input logic [tick_w-1:0] tick);
    logic [axi_data_w-1:0] w;
    w       = '0;
    w[0]    = enable;
    w[1]    = load;
    w[2]    = clear;
    w[3]    = oneshot;
    w[15:8] = tick;
    return w;
  endfunction

  // Count, prescaler, tick flag, watermark flag
  function automatic logic [axi_data_w-1:0] status_word(input logic [cnt_w-1:0] count,
      input logic [tick_w-1:0] presc, input logic [tick_w-1:0] tick, input logic [cnt_w-1:0] wm);
    logic [axi_data_w-1:0] w;
    w        = '0;
    w[15:0]  = count;
    w[23:16] = presc;
    w[24]    = presc >= tick;
    w[25]    = count >= wm;
    return w;
  endfunction

  // ----------------------------------------
  // Compare and error tasks
  // ----------------------------------------
  task automatic check_data(input string name, input logic [axi_data_w-1:0] got,
      input logic [axi_data_w-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_vled(input string name, input logic [vled_w-1:0] got,
      input logic [vled_w-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("ERROR: timed out, %s", what);
  endtask

  // ----------------------------------------
  // Bus tasks
  // ----------------------------------------
  // Inputs change 2 ns after the edge
  task automatic next_drive_point();
    @(posedge clk_main_a0);
    #2;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_main_n_sync && cycles < reset_timeout) begin
      next_drive_point();
      cycles++;
    end
    if (!rst_main_n_sync) begin
      report_timeout("reset was never released");
    end
  endtask

  task automatic axi_write(input logic [axi_addr_w-1:0] addr,
      input logic [axi_data_w-1:0] data, input int bready_delay);
    int         cycles;
    int         stall;
    bit         aw_now;
    bit         w_now;
    bit         b_now;
    logic [1:0] resp;
    cycles         = 0;
    stall          = 0;
    b_now          = 1'b0;
    resp           = '0;
    sh_ocl_awaddr  = addr;
    sh_ocl_awvalid = 1'b1;
    sh_ocl_wdata   = data;
    sh_ocl_wstrb   = '1;
    sh_ocl_wvalid  = 1'b1;
    // AW and W offered together, transfers sampled mid-cycle
    while ((sh_ocl_awvalid || sh_ocl_wvalid) && cycles < bus_timeout) begin
      @(negedge clk_main_a0);
      aw_now = sh_ocl_awvalid && ocl_sh_awready;
      w_now  = sh_ocl_wvalid && ocl_sh_wready;
      next_drive_point();
      if (aw_now) begin
        sh_ocl_awvalid = 1'b0;
      end
      if (w_now) begin
        sh_ocl_wvalid = 1'b0;
      end
      cycles++;
    end
    if (sh_ocl_awvalid || sh_ocl_wvalid) begin
      report_timeout("write address or data not accepted");
      sh_ocl_awvalid = 1'b0;
      sh_ocl_wvalid  = 1'b0;
    end else begin
      // Hold bready low for bready_delay cycles of bvalid
      sh_ocl_bready = (bready_delay == 0);
      cycles        = 0;
      while (!b_now && cycles < bus_timeout) begin
        @(negedge clk_main_a0);
        b_now = ocl_sh_bvalid && sh_ocl_bready;
        resp  = ocl_sh_bresp;
        if (ocl_sh_bvalid) begin
          stall++;
        end
        next_drive_point();
        if (stall >= bready_delay) begin
          sh_ocl_bready = 1'b1;
        end
        cycles++;
      end
      sh_ocl_bready = 1'b0;
      if (b_now) begin
        check_resp("ocl_sh_bresp", resp, 2'b00);
      end else begin
        report_timeout("write response never arrived");
      end
    end
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr,
      output logic [axi_data_w-1:0] data);
    int         cycles;
    bit         ar_done;
    bit         r_done;
    bit         r_seen;
    logic [1:0] resp;
    cycles         = 0;
    ar_done        = 1'b0;
    r_done         = 1'b0;
    r_seen         = 1'b0;
    resp           = '0;
    data           = '0;
    sh_ocl_araddr  = addr;
    sh_ocl_arvalid = 1'b1;
    while (!ar_done && cycles < bus_timeout) begin
      @(negedge clk_main_a0);
      ar_done = ocl_sh_arready;
      next_drive_point();
      cycles++;
    end
    sh_ocl_arvalid = 1'b0;
    if (!ar_done) begin
      report_timeout("read address not accepted");
    end else begin
      // rready held off for the first cycle of rvalid
      sh_ocl_rready = 1'b0;
      cycles        = 0;
      while (!r_done && cycles < bus_timeout) begin
        @(negedge clk_main_a0);
        r_done = ocl_sh_rvalid && sh_ocl_rready;
        r_seen = ocl_sh_rvalid;
        data   = ocl_sh_rdata;
        resp   = ocl_sh_rresp;
        next_drive_point();
        if (r_seen) begin
          sh_ocl_rready = 1'b1;
        end
        cycles++;
      end
      sh_ocl_rready = 1'b0;
      if (r_done) begin
        check_resp("ocl_sh_rresp", resp, 2'b00);
      end else begin
        report_timeout("read data never returned");
      end
    end
  endtask

  // LED output polled until it settles
  task automatic poll_vled(input logic [vled_w-1:0] exp);
    int                cycles;
    bit                matched;
    logic [vled_w-1:0] got;
    cycles  = 0;
    matched = 1'b0;
    got     = '0;
    while (!matched && cycles < vled_timeout) begin
      @(negedge clk_main_a0);
      got     = cl_sh_status_vled;
      matched = (got == exp);
      next_drive_point();
      cycles++;
    end
    check_vled("cl_sh_status_vled", got, exp);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset_values();
    logic [axi_data_w-1:0] rd;
    @(negedge clk_main_a0);
    check_data("ocl_sh_awready", {31'b0, ocl_sh_awready}, 32'd1);
    check_data("ocl_sh_arready", {31'b0, ocl_sh_arready}, 32'd1);
    check_vled("cl_sh_status_vled", cl_sh_status_vled, '0);
    next_drive_point();
    axi_read(hello_world_addr, rd);
    check_data("hello_world", rd, '0);
    axi_read(vled_addr, rd);
    check_data("vled", rd, '0);
    axi_read(cnt_ctrl_addr, rd);
    check_data("cnt_ctrl", rd, '0);
    axi_read(cnt_load_addr, rd);
    check_data("cnt_load", rd, '0);
    axi_read(cnt_watermark_addr, rd);
    check_data("cnt_watermark", rd, '0);
    // Idle prescaler and zero watermark, both flags set
    axi_read(cnt_status_addr, rd);
    check_data("cnt_status", rd, status_word(16'h0000, 8'h00, 8'h00, 16'h0000));
    axi_read(32'h0000_0600, rd);
    check_data("unmapped", rd, 32'hDEAD_DEAD);
  endtask

  task automatic test_hello_swap();
    logic [axi_data_w-1:0] data;
    logic [axi_data_w-1:0] rd;
    for (int i = 0; i < 10; i++) begin
      data = $random(seed);
      axi_write(hello_world_addr, data, 0);
      axi_read(hello_world_addr, rd);
      check_data("hello_world", rd, byte_swap(data));
    end
  endtask

  task automatic test_vled_mask();
    logic [axi_data_w-1:0] data;
    logic [axi_data_w-1:0] dip_word;
    logic [axi_data_w-1:0] rd;
    for (int i = 0; i < 6; i++) begin
      data     = $random(seed);
      dip_word = $random(seed);
      axi_write(hello_world_addr, data, 0);
      sh_cl_status_vdip = dip_word[vled_w-1:0];
      poll_vled(data[vled_w-1:0] & dip_word[vled_w-1:0]);
      // Shadow reads back unmasked
      axi_read(vled_addr, rd);
      check_data("vled", rd, {16'h0000, data[vled_w-1:0]});
    end
  endtask

  task automatic test_load_clear();
    logic [axi_data_w-1:0] value_word;
    logic [cnt_w-1:0]      value;
    logic [axi_data_w-1:0] rd;
    value_word = $random(seed);
    value      = value_word[cnt_w-1:0];
    axi_write(cnt_load_addr, {16'h0000, value}, 0);
    axi_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0, 8'h00), 0);
    axi_read(cnt_status_addr, rd);
    check_data("cnt_status", rd, status_word(value, 8'h00, 8'h00, 16'h0000));
    // Command bits are not kept
    axi_read(cnt_ctrl_addr, rd);
    check_data("cnt_ctrl", rd, '0);
    axi_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 8'h00), 0);
    axi_read(cnt_status_addr, rd);
    check_data("cnt_status", rd, status_word(16'h0000, 8'h00, 8'h00, 16'h0000));
  endtask

  task automatic test_oneshot();
    logic [cnt_w-1:0]      wm;
    logic [axi_data_w-1:0] rd;
    int                    reads;
    wm    = 16'hFFF8;
    reads = 0;
    axi_write(cnt_watermark_addr, {16'h0000, wm}, 0);
    axi_write(cnt_load_addr, 32'h0000_FFF0, 0);
    axi_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0, 8'h00), 0);
    axi_read(cnt_status_addr, rd);
    check_data("cnt_status", rd, status_word(16'hFFF0, 8'h00, 8'h00, wm));
    axi_write(cnt_ctrl_addr, ctrl_word(1'b1, 1'b0, 1'b0, 1'b1, 8'h00), 0);
    // tick_value 0 fires every cycle, prescaler stays at 0
    while (rd[cnt_w-1:0] != 16'hFFFF && reads < 40) begin
      axi_read(cnt_status_addr, rd);
      check_data("cnt_status", rd, status_word(rd[cnt_w-1:0], 8'h00, 8'h00, wm));
      reads++;
    end
    if (rd[cnt_w-1:0] != 16'hFFFF) begin
      report_timeout("count never reached 0xFFFF");
    end
    // Must stay parked at the top
    for (int i = 0; i < 5; i++) begin
      axi_read(cnt_status_addr, rd);
      check_data("cnt_status", rd, status_word(16'hFFFF, 8'h00, 8'h00, wm));
    end
    axi_read(cnt_ctrl_addr, rd);
    check_data("cnt_ctrl", rd, ctrl_word(1'b1, 1'b0, 1'b0, 1'b1, 8'h00));
    axi_write(cnt_ctrl_addr, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 8'h00), 0);
  endtask

  task automatic test_bready_stall();
    logic [axi_data_w-1:0] data;
    logic [axi_data_w-1:0] rd;
    data = '0;
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      axi_write(hello_world_addr, data, 3 + 2 * i);
    end
    axi_read(hello_world_addr, rd);
    check_data("hello_world", rd, byte_swap(data));
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    seed              = 32'hde2a2b3f;
    mismatch_count    = 0;
    timeout_count     = 0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = '0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = '0;
    sh_ocl_wstrb      = '0;
    sh_ocl_bready     = 1'b0;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = '0;
    sh_ocl_rready     = 1'b0;
    sh_cl_status_vdip = '0;
    wait_reset_release();
    test_reset_values();
    test_hello_swap();
    test_vled_mask();
    test_load_clear();
    test_oneshot();
    test_bready_stall();
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatch_count, timeout_count, UUT.u_ocl_slave.u_props.fail_count);
    if (mismatch_count == 0 && timeout_count == 0 &&
        UUT.u_ocl_slave.u_props.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
design/cl_ro_pkg.sv
design/ocl_slave.sv
design/ocl_regs.sv
design/vled_status.sv
design/tick_counter.sv
design/cl_ro_top.sv
tests/clk_gen.sv
tests/cl_ro_properties.sv
tests/tb_cl_ro.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_cl_ro
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
BUILD_ARGS ?= --binary -j 0
SIM_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_ARGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
